//--- all.f
src/tone_gen_pkg.sv
src/phase_sine_dds.sv
src/gain_ramp.sv
src/volume_adjuster.sv
src/tone_channel_top.sv
bench/tb_clock_gen.sv
bench/tone_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tone channel testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tone_channel_tb \
    -f all.f \
    -o tone_channel_sim

# The simulator stops with an error status on failure, the log decides
./obj_dir/tone_channel_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- bench/tone_channel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tone_channel_tb;

    localparam int RAMP_STEP = 64;
    localparam int CLK_PERIOD_NS = 10;
    // Strobe counts per test section
    localparam int N_FIRST = 4;
    localparam int N_RAMP = 281;
    localparam int N_SINE = 120;
    localparam int N_VOL = 6 * 280;
    localparam int N_WRAP = 30;
    localparam int N_AFTER = 1 + 268;
    localparam int STROBE_TOTAL = N_FIRST + N_RAMP + N_SINE + N_VOL + N_WRAP + N_AFTER;
    localparam int WATCHDOG_CYCLES = STROBE_TOTAL * 12 + 600;

    logic a_clk;
    logic por_reset;
    logic run_reset = 1'b0;
    wire  reset = por_reset | run_reset;

    tone_gen_pkg::phase_t     freq_word;
    logic                     freq_load;
    tone_gen_pkg::gain_t      volume;
    logic                     volume_load;
    logic                     sample_strobe;
    tone_gen_pkg::half_word_t aux_sample;
    tone_gen_pkg::out_word_t  out_tdata;
    logic                     out_tvalid;

    // Model state
    int seed = 89;
    int cycle = 0;
    int sent = 0;
    int dropped = 0;
    int checked = 0;
    tone_gen_pkg::phase_t model_phase = '0;
    tone_gen_pkg::phase_t model_freq = '0;
    tone_gen_pkg::gain_t  model_target = '0;
    tone_gen_pkg::gain_t  model_gain = '0;
    tone_gen_pkg::out_word_t exp_q[$];
    int due_q[$];

    tb_clock_gen clock_gen_i
    (
        .a_clk (a_clk),
        .reset (por_reset)
    );

    tone_channel_top #(
        .RAMP_STEP (RAMP_STEP)
    ) tone_channel_top_i
    (
        .a_clk         (a_clk),
        .reset         (reset),
        .freq_word     (freq_word),
        .freq_load     (freq_load),
        .volume        (volume),
        .volume_load   (volume_load),
        .sample_strobe (sample_strobe),
        .aux_sample    (aux_sample),
        .out_tdata     (out_tdata),
        .out_tvalid    (out_tvalid)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Parabolic half-wave from the top 16 phase bits
    function automatic tone_gen_pkg::sample_t sine_of(input tone_gen_pkg::phase_t ph);
        int u;
        int mag;
        u = int'(ph[30:16]);
        mag = (u * (32768 - u)) / 32768;
        if (mag > tone_gen_pkg::SINE_PEAK)
            mag = tone_gen_pkg::SINE_PEAK;
        if (ph[31])
            mag = -mag;
        return tone_gen_pkg::sample_t'(mag);
    endfunction

    // Q14 scaling with floor division by 2^14
    function automatic tone_gen_pkg::half_word_t scale_of(input tone_gen_pkg::sample_t s,
                                                          input tone_gen_pkg::gain_t g);
        int prod;
        prod = int'(s) * int'(g);
        return tone_gen_pkg::half_word_t'(prod >>> tone_gen_pkg::GAIN_Q);
    endfunction

    // Bounded step toward the target
    function automatic tone_gen_pkg::gain_t ramp_toward(input tone_gen_pkg::gain_t cur,
                                                        input tone_gen_pkg::gain_t goal);
        int diff;
        diff = int'(goal) - int'(cur);
        if (diff > RAMP_STEP)
            return tone_gen_pkg::gain_t'(int'(cur) + RAMP_STEP);
        if (diff < -RAMP_STEP)
            return tone_gen_pkg::gain_t'(int'(cur) - RAMP_STEP);
        return goal;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input tone_gen_pkg::out_word_t got,
                              input tone_gen_pkg::out_word_t exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_half(input string name, input tone_gen_pkg::half_word_t got,
                              input tone_gen_pkg::half_word_t exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Idle gap with optional loads in its last cycle and then one strobe
    task automatic send_sample(input bit load_f, input tone_gen_pkg::phase_t f,
                               input bit load_v, input tone_gen_pkg::gain_t v);
        int gap;
        tone_gen_pkg::half_word_t aux;
        tone_gen_pkg::sample_t s;
        gap = 2 + ({$random(seed)} % 6);
        aux = tone_gen_pkg::half_word_t'($random(seed));
        repeat (gap - 1) @(posedge a_clk);
        @(posedge a_clk);
        if (load_f)
        begin
            freq_load <= 1'b1;
            freq_word <= f;
            model_freq = f;
        end
        if (load_v)
        begin
            volume_load <= 1'b1;
            volume      <= v;
            model_target = (v > tone_gen_pkg::GAIN_UNITY) ? tone_gen_pkg::GAIN_UNITY : v;
        end
        @(posedge a_clk);
        freq_load     <= 1'b0;
        volume_load   <= 1'b0;
        sample_strobe <= 1'b1;
        aux_sample    <= aux;
        // Sample uses the gain before this sample's step
        model_phase = model_phase + model_freq;
        s = sine_of(model_phase);
        exp_q.push_back({scale_of(s, model_gain), aux});
        due_q.push_back(cycle + 5);
        model_gain = ramp_toward(model_gain, model_target);
        sent++;
        @(posedge a_clk);
        sample_strobe <= 1'b0;
    endtask

    // Reset with one sample still in flight
    task automatic reset_mid_run();
        send_sample(1'b0, '0, 1'b0, '0);
        @(posedge a_clk);
        run_reset <= 1'b1;
        dropped += exp_q.size();
        exp_q.delete();
        due_q.delete();
        model_phase = '0;
        model_freq = '0;
        model_target = '0;
        model_gain = '0;
        repeat (3) @(posedge a_clk);
        run_reset <= 1'b0;
    endtask

    ////////////////////
    // Output monitor
    ////////////////////

    // Sampled mid-cycle away from the driving edge
    always @(negedge a_clk)
    begin : monitor
        tone_gen_pkg::out_word_t exp_word;
        cycle = cycle + 1;
        if (out_tvalid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Unexpected out_tvalid at %0t ns with no sample pending", $time);
                fail_run();
            end
            if (due_q[0] != cycle)
            begin
                $display("out_tvalid came at cycle %0d, expected at cycle %0d", cycle, due_q[0]);
                fail_run();
            end
            exp_word = exp_q.pop_front();
            void'(due_q.pop_front());
            check_half("out_tdata[31:16]", out_tdata[31:16], exp_word[31:16]);
            check_half("out_tdata[15:0]", out_tdata[15:0], exp_word[15:0]);
            check_word("out_tdata", out_tdata, exp_word);
            checked++;
        end
        else if (exp_q.size() != 0 && due_q[0] <= cycle)
        begin
            $display("out_tvalid missing at cycle %0d, %0t ns", cycle, $time);
            fail_run();
        end
    end

    // Watchdog sized from the strobe count
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin : test_flow
        tone_gen_pkg::phase_t f;
        tone_gen_pkg::gain_t v;
        bit lf;
        freq_word     = '0;
        freq_load     = 1'b0;
        volume        = '0;
        volume_load   = 1'b0;
        sample_strobe = 1'b0;
        aux_sample    = '0;
        while (por_reset)
            @(posedge a_clk);
        // Quiet after reset and then samples at gain 0
        repeat (20) @(posedge a_clk);
        for (int i = 0; i < N_FIRST; i++)
            send_sample(1'b1, tone_gen_pkg::phase_t'($random(seed)), 1'b0, '0);
        // Ramp to unity and then plain sine at full gain
        send_sample(1'b0, '0, 1'b1, tone_gen_pkg::GAIN_UNITY);
        for (int i = 1; i < N_RAMP + N_SINE; i++)
            send_sample(1'b1, tone_gen_pkg::phase_t'($random(seed)), 1'b0, '0);
        // Random volume rounds with the first one above unity
        for (int r = 0; r < N_VOL / 280; r++)
        begin
            v = (r == 0) ? 16'hFFFF : tone_gen_pkg::gain_t'($random(seed));
            send_sample(1'b0, '0, 1'b1, v);
            for (int i = 1; i < 280; i++)
            begin
                lf = 1'($random(seed));
                f = tone_gen_pkg::phase_t'($random(seed));
                send_sample(lf, f, 1'b0, '0);
            end
        end
        // Large step so the phase wraps every few samples
        for (int i = 0; i < N_WRAP; i++)
            send_sample(i == 0, 32'hF000_0001, 1'b0, '0);
        // Mid-run reset and then quarter-turn steps while the gain ramps up from zero
        reset_mid_run();
        send_sample(1'b1, 32'h4000_0000, 1'b1, tone_gen_pkg::GAIN_UNITY);
        for (int i = 1; i < N_AFTER; i++)
            send_sample(1'b0, '0, 1'b0, '0);
        while (exp_q.size() != 0)
            @(posedge a_clk);
        repeat (10) @(posedge a_clk);
        if (checked != sent - dropped)
        begin
            $display("Checked %0d outputs, expected %0d", checked, sent - dropped);
            fail_run();
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 8
)
(
    output logic a_clk,
    output logic reset
);

    // Free running clock, 10 ns period
    initial
    begin
        a_clk = 1'b0;
        forever #(HALF_PERIOD_NS) a_clk = ~a_clk;
    end

    // Power-on reset
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge a_clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- src/tone_channel_top.sv
`timescale 1ns/1ps
`default_nettype none

module tone_channel_top #(
    // Largest gain change per sample
    parameter int RAMP_STEP = 64
)
(
    input  wire                         a_clk,
    input  wire                         reset,
    input  wire tone_gen_pkg::phase_t     freq_word,
    input  wire                         freq_load,
    input  wire tone_gen_pkg::gain_t      volume,
    input  wire                         volume_load,
    input  wire                         sample_strobe,
    input  wire tone_gen_pkg::half_word_t aux_sample,
    output tone_gen_pkg::out_word_t     out_tdata,
    output logic                        out_tvalid
);

    ////////////////////
    // Internal wiring
    ////////////////////

    tone_gen_pkg::sample_t sample;
    logic                  sample_valid;
    tone_gen_pkg::gain_t   gain;

    // Channel A synthesis, sample 2 cycles after strobe
    phase_sine_dds phase_sine_dds_i
    (
        .a_clk         (a_clk),
        .reset         (reset),
        .freq_word     (freq_word),
        .freq_load     (freq_load),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .sample_valid  (sample_valid)
    );

    // Volume smoothing
    gain_ramp #(
        .RAMP_STEP (RAMP_STEP)
    ) gain_ramp_i
    (
        .a_clk        (a_clk),
        .reset        (reset),
        .volume       (volume),
        .volume_load  (volume_load),
        .sample_valid (sample_valid),
        .gain         (gain)
    );

    // Scale and pack, output 2 cycles after sample
    volume_adjuster volume_adjuster_i
    (
        .a_clk        (a_clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .gain         (gain),
        .aux_sample   (aux_sample),
        .out_tdata    (out_tdata),
        .out_tvalid   (out_tvalid)
    );

endmodule

`default_nettype wire

//--- src/volume_adjuster.sv
`timescale 1ns/1ps
`default_nettype none

module volume_adjuster
(
    input  wire                         a_clk,
    input  wire                         reset,
    input  wire tone_gen_pkg::sample_t    sample,
    input  wire                         sample_valid,
    input  wire tone_gen_pkg::gain_t      gain,
    input  wire tone_gen_pkg::half_word_t aux_sample,
    output tone_gen_pkg::out_word_t     out_tdata,
    output logic                        out_tvalid
);

    ////////////////////
    // Stage one
    ////////////////////

    tone_gen_pkg::sample_t    x_reg;
    tone_gen_pkg::gain_t      v_reg;
    tone_gen_pkg::half_word_t aux_reg;
    logic                     valid1;

    // Capture operands with the sample
    always_ff @(posedge a_clk)
    begin
        if (sample_valid)
        begin
            x_reg   <= sample;
            v_reg   <= gain;
            aux_reg <= aux_sample;
        end
    end

    ////////////////////
    // Stage two
    ////////////////////

    // 14-bit signed times 17-bit positive gain
    logic signed [30:0] product;
    logic signed [30:0] scaled;
    tone_gen_pkg::half_word_t chan_a;

    always_comb
    begin
        product = x_reg * $signed({1'b0, v_reg});
        // Drop the Q14 fraction, rounds toward minus infinity
        scaled  = product >>> tone_gen_pkg::GAIN_Q;
        // Fits in 14 bits so the low 16 are already sign-extended
        chan_a  = scaled[15:0];
    end

    always_ff @(posedge a_clk)
    begin
        if (valid1)
            out_tdata <= {chan_a, aux_reg};
    end

    // Valid follows data through both stages
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            valid1     <= 1'b0;
            out_tvalid <= 1'b0;
        end
        else
        begin
            valid1     <= sample_valid;
            out_tvalid <= valid1;
        end
    end

endmodule

`default_nettype wire

//--- src/gain_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module gain_ramp #(
    parameter int RAMP_STEP = 64
)
(
    input  wire                    a_clk,
    input  wire                    reset,
    input  wire tone_gen_pkg::gain_t volume,
    input  wire                    volume_load,
    input  wire                    sample_valid,
    output tone_gen_pkg::gain_t    gain
);

    tone_gen_pkg::gain_t target;
    tone_gen_pkg::gain_t gain_next;
    // Remaining distance in either direction
    tone_gen_pkg::gain_t dist_up;
    tone_gen_pkg::gain_t dist_dn;

    ////////////////////
    // Next gain
    ////////////////////

    always_comb
    begin
        dist_up = target - gain;
        dist_dn = gain - target;
        if (gain < target)
        begin
            // Land on target when close enough
            if (dist_up <= 16'(RAMP_STEP))
                gain_next = target;
            else
                gain_next = gain + 16'(RAMP_STEP);
        end
        else if (gain > target)
        begin
            if (dist_dn <= 16'(RAMP_STEP))
                gain_next = target;
            else
                gain_next = gain - 16'(RAMP_STEP);
        end
        else
            gain_next = gain;
    end

    ////////////////////
    // Target and applied gain
    ////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            target <= '0;
            gain   <= '0;
        end
        else
        begin
            // Clamp at unity
            if (volume_load)
                target <= (volume > tone_gen_pkg::GAIN_UNITY) ? tone_gen_pkg::GAIN_UNITY
                                                              : volume;
            // One step per sample, after this sample used the old value
            if (sample_valid)
                gain <= gain_next;
        end
    end

endmodule

`default_nettype wire

//--- src/phase_sine_dds.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sine_dds
(
    input  wire                    a_clk,
    input  wire                    reset,
    input  wire tone_gen_pkg::phase_t freq_word,
    input  wire                    freq_load,
    input  wire                    sample_strobe,
    output tone_gen_pkg::sample_t  sample,
    output logic                   sample_valid
);

    ////////////////////
    // Phase accumulator
    ////////////////////

    tone_gen_pkg::phase_t freq_reg;
    tone_gen_pkg::phase_t phase;
    // Strobe delayed to line up with the new phase
    logic strobe_d;

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            freq_reg <= '0;
            phase    <= '0;
            strobe_d <= 1'b0;
        end
        else
        begin
            // New frequency used from the next cycle on
            if (freq_load)
                freq_reg <= freq_word;
            // Advance once per sample, wraps at 2^32
            if (sample_strobe)
                phase <= phase + freq_reg;
            strobe_d <= sample_strobe;
        end
    end

    ////////////////////
    // Parabolic half-wave
    ////////////////////

    // Position inside the half period
    logic [14:0] u;
    logic [15:0] u_comp;
    // u * (32768 - u), up to 2^28
    logic [30:0] para;
    logic [15:0] para_top;
    tone_gen_pkg::sample_t mag;
    tone_gen_pkg::sample_t sample_next;

    always_comb
    begin
        u        = phase[30:16];
        u_comp   = 16'd32768 - {1'b0, u};
        para     = u * u_comp;
        para_top = para[30:15];
        // Peak of the parabola is 8192, one above the cap
        if (para_top > 16'(tone_gen_pkg::SINE_PEAK))
            mag = tone_gen_pkg::sample_t'(tone_gen_pkg::SINE_PEAK);
        else
            mag = tone_gen_pkg::sample_t'(para_top);
        // Second half period is the negative lobe
        sample_next = phase[31] ? -mag : mag;
    end

    // Sample register, no reset on payload
    always_ff @(posedge a_clk)
    begin
        if (strobe_d)
            sample <= sample_next;
    end

    always_ff @(posedge a_clk)
    begin
        if (reset)
            sample_valid <= 1'b0;
        else
            sample_valid <= strobe_d;
    end

endmodule

`default_nettype wire

//--- src/tone_gen_pkg.sv
`default_nettype none

package tone_gen_pkg;

    ////////////////////
    // Data types
    ////////////////////

    // Synthesised channel A sample
    typedef logic signed [13:0] sample_t;

    // Gain in Q14 with unity at 16384
    typedef logic [15:0] gain_t;

    // Phase accumulator and frequency word
    typedef logic [31:0] phase_t;

    // One channel's half of the output word
    typedef logic [15:0] half_word_t;

    // Channel A in the upper half, channel B in the lower half
    typedef logic [31:0] out_word_t;

    ////////////////////
    // Gain and sine constants
    ////////////////////

    // Fraction bits of gain_t
    localparam int GAIN_Q = 14;
    // Largest gain, loaded targets clamp here
    localparam gain_t GAIN_UNITY = 16'd16384;
    // Largest synthesised magnitude
    localparam int SINE_PEAK = 8191;

endpackage

`default_nettype wire
